// ==== hw/md_iter_engine.sv ====
// Iterative engine with product/remainder register, step counter, stall and flush control
`timescale 1ns/1ps

module md_iter_engine
    import muldiv_pkg::*;
#(
    parameter int unsigned FAST_MUL = 0
) (
    input  logic      s_clk_i,
    input  logic      arst_n_i,
    input  logic      compute_i,
    input  logic      stall_i,
    input  logic      flush_i,
    input  md_prep_t  prep_i,
    output md_state_t state_o,
    output logic      finished_o
);

    // Control state
    logic [CNT_W-1:0]  cnt_q;
    md_func_e          func_q;
    logic              neg_q;
    // Payload
    logic [PROD_W-1:0] prod_q;
    logic [XLEN-1:0]   opnd_q;

    logic              idle;
    logic              done;
    logic              busy;

    // Division datapath
    logic [XLEN+1:0]   div_diff;
    // Radix-4 datapath
    logic [XLEN:0]     mul_op1;
    logic [XLEN:0]     mul_op2;
    logic [XLEN+1:0]   mul_sum;
    logic [XLEN-1:0]   mplier_rem;
    logic              mplier_zero;
    logic [XLEN:0]     init_sum;
    // Single-step datapath
    logic [2*XLEN-1:0] fast_prod;

    logic [PROD_W-1:0] step_prod;
    logic [CNT_W-1:0]  step_cnt;
    logic [PROD_W-1:0] start_prod;
    logic [CNT_W-1:0]  start_cnt;
    logic [XLEN-1:0]   start_opnd;

    assign idle = cnt_q == CNT_IDLE;
    assign done = cnt_q == '0;
    assign busy = ~idle & ~done;

    // Shifted partial remainder minus divisor
    // Borrow ends up in the top bit
    assign div_diff = {1'b0, prod_q[PROD_W-1:XLEN]} + {2'b11, opnd_q};

    // Three-operand add of partial sum and multiplicand gated by the low pair
    assign mul_op1 = {1'b0, opnd_q & {XLEN{prod_q[0]}}};
    assign mul_op2 = {opnd_q & {XLEN{prod_q[1]}}, 1'b0};
    assign mul_sum = {1'b0, prod_q[PROD_W-1:XLEN]} + {1'b0, mul_op1} + {1'b0, mul_op2};

    // Remaining multiplier bits sit in the low cnt_q positions
    assign mplier_rem  = prod_q[XLEN-1:0] << (CNT_W'(XLEN) - cnt_q);
    assign mplier_zero = mplier_rem == '0;

    // First pair handled at load
    // Pair 11 needs a full step
    assign init_sum = prep_i.op_b[0] ? {1'b0, prep_i.mag_a} :
                      prep_i.op_b[1] ? {prep_i.mag_a, 1'b0} : '0;

    assign fast_prod = opnd_q * prod_q[XLEN-1:0];

    // One iteration
    always_comb begin
        if (func_q[2]) begin
            // Restoring step
            // Quotient bit shifts in at the bottom
            // On a borrow the shifted partial remainder is kept
            step_prod = {div_diff[XLEN+1] ? prod_q[PROD_W-2:XLEN] : div_diff[XLEN-1:0],
                         prod_q[XLEN-1:0], ~div_diff[XLEN+1]};
            step_cnt  = cnt_q - CNT_W'(1);
        end else if (FAST_MUL != 0) begin
            step_prod = {1'b0, fast_prod};
            step_cnt  = '0;
        end else if (mplier_zero) begin
            // Nothing left to add
            // Align the product and stop
            step_prod = prod_q >> cnt_q;
            step_cnt  = '0;
        end else if ((prod_q[3:2] == 2'b00) && (cnt_q != CNT_W'(2))) begin
            // Next pair is zero and retires in the same step
            step_prod = {3'b000, mul_sum, prod_q[XLEN-1:4]};
            step_cnt  = cnt_q - CNT_W'(4);
        end else begin
            step_prod = {1'b0, mul_sum, prod_q[XLEN-1:2]};
            step_cnt  = cnt_q - CNT_W'(2);
        end
    end

    // Load values for a new request
    always_comb begin
        start_opnd = prep_i.func[2] ? prep_i.op_b : prep_i.mag_a;
        if (prep_i.direct) begin
            start_prod = prep_i.direct_val;
            start_cnt  = '0;
        end else if (prep_i.func[2]) begin
            // 33 steps
            // The first one only shifts in the dividend MSB
            start_prod = {{(XLEN+1){1'b0}}, prep_i.mag_a};
            start_cnt  = CNT_W'(XLEN + 1);
        end else if (FAST_MUL != 0) begin
            start_prod = {{(XLEN+1){1'b0}}, prep_i.op_b};
            start_cnt  = CNT_W'(1);
        end else if (prep_i.op_b[1:0] == 2'b11) begin
            start_prod = {{(XLEN+1){1'b0}}, prep_i.op_b};
            start_cnt  = CNT_W'(XLEN);
        end else begin
            start_prod = {2'b00, init_sum, prep_i.op_b[XLEN-1:2]};
            start_cnt  = CNT_W'(XLEN - 2);
        end
    end

    // Flush beats everything
    // A held result keeps all state
    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q  <= CNT_IDLE;
            func_q <= MD_MUL;
            neg_q  <= 1'b0;
            prod_q <= '0;
        end else if (flush_i) begin
            cnt_q <= CNT_IDLE;
            neg_q <= 1'b0;
        end else if (busy) begin
            prod_q <= step_prod;
            cnt_q  <= step_cnt;
        end else if (idle && compute_i) begin
            prod_q <= start_prod;
            cnt_q  <= start_cnt;
            func_q <= prep_i.func;
            neg_q  <= prep_i.negate;
        end else if (done && !stall_i) begin
            cnt_q <= CNT_IDLE;
        end
    end

    // Multiplicand or negated divisor for the whole operation
    always_ff @(posedge s_clk_i) begin
        if (idle && compute_i) begin
            opnd_q <= start_opnd;
        end
    end

    assign state_o.prod   = prod_q;
    assign state_o.func   = func_q;
    assign state_o.negate = neg_q;
    assign finished_o     = done;

endmodule

// ==== hw/md_operand_prep.sv ====
// Operand preparation: function decode, magnitudes, negate flag and direct-result detection
`timescale 1ns/1ps

module md_operand_prep
    import muldiv_pkg::*;
(
    input  md_req_t  req_i,
    output md_prep_t prep_o
);

    logic            is_div;
    logic            is_rem;
    logic            signed_a;
    logic            signed_b;
    logic            neg_a;
    logic            neg_b;
    logic [XLEN-1:0] a_rev;
    logic [XLEN-1:0] b_rev;
    logic            a_zero;
    logic            b_zero;
    logic            b_mone;
    logic            a_minneg;
    logic            sovrflw;
    logic            div_zero;
    logic            direct;

    assign is_div = req_i.func[2];
    assign is_rem = req_i.func[2] & req_i.func[1];

    // Signed divisor / multiplier
    assign signed_b = (req_i.func == MD_MUL) | (req_i.func == MD_MULH) |
                      (req_i.func == MD_DIV) | (req_i.func == MD_REM);
    // MULHSU has only a signed multiplicand
    assign signed_a = signed_b | (req_i.func == MD_MULHSU);

    // Operand is negative and must be flipped
    assign neg_a = signed_a & req_i.op_a[XLEN-1];
    assign neg_b = signed_b & req_i.op_b[XLEN-1];

    // Two's complement of each operand
    assign a_rev = ~req_i.op_a + XLEN'(1);
    assign b_rev = ~req_i.op_b + XLEN'(1);

    // Corner-case detection on the raw operands
    assign a_zero   = req_i.op_a == '0;
    assign b_zero   = req_i.op_b == '0;
    assign b_mone   = req_i.op_b == '1;
    assign a_minneg = req_i.op_a == {1'b1, {(XLEN-1){1'b0}}};
    // -2^31 / -1 does not fit, defined result instead
    assign sovrflw  = ((req_i.func == MD_DIV) | (req_i.func == MD_REM)) & a_minneg & b_mone;
    assign div_zero = is_div & b_zero;
    // Zero multiplier also gives zero, so b_zero covers both cases
    assign direct   = a_zero | b_zero | sovrflw;

    always_comb begin
        prep_o.func   = req_i.func;
        prep_o.direct = direct;

        // Engine works on magnitudes only
        prep_o.mag_a = neg_a ? a_rev : req_i.op_a;

        // Divider subtracts by adding, so divisor always ends up negative
        // Multiplier always ends up positive
        prep_o.op_b = (neg_b ^ is_div) ? b_rev : req_i.op_b;

        // Product and quotient sign from both operands
        // Remainder follows the dividend
        if (direct) begin
            prep_o.negate = 1'b0;
        end else if (is_rem) begin
            prep_o.negate = neg_a;
        end else begin
            prep_o.negate = neg_a ^ neg_b;
        end

        // Layout matches the engine: remainder on top, quotient in the low word
        if (sovrflw) begin
            // Quotient is the dividend, remainder zero
            prep_o.direct_val = {{(XLEN+1){1'b0}}, req_i.op_a};
        end else if (div_zero) begin
            // Quotient all ones, remainder is the dividend
            prep_o.direct_val = {req_i.op_a, 1'b0, {XLEN{1'b1}}};
        end else begin
            // Zero dividend, multiplicand or multiplier
            prep_o.direct_val = '0;
        end
    end

endmodule

// ==== hw/md_result_sel.sv ====
// Result stage: sign restoration and upper/lower word selection
`timescale 1ns/1ps

module md_result_sel
    import muldiv_pkg::*;
(
    input  md_state_t       state_i,
    output logic [XLEN-1:0] result_o
);

    logic [2*XLEN-1:0] prod_rev;
    logic [XLEN-1:0]   rem_rev;
    logic [2*XLEN-1:0] mul_res;
    logic [XLEN-1:0]   quot;
    logic [XLEN-1:0]   rem;
    logic [2*XLEN-1:0] full_res;
    logic              upper;

    // Negated product, its low word doubles as the negated quotient
    assign prod_rev = ~state_i.prod[2*XLEN-1:0] + (2*XLEN)'(1);
    // Remainder sits above the quotient and guard bit
    assign rem_rev  = ~state_i.prod[PROD_W-1:XLEN+1] + XLEN'(1);

    assign mul_res = state_i.negate ? prod_rev : state_i.prod[2*XLEN-1:0];
    assign quot    = mul_res[XLEN-1:0];
    assign rem     = state_i.negate ? rem_rev : state_i.prod[PROD_W-1:XLEN+1];

    // Division result packed as remainder:quotient
    assign full_res = state_i.func[2] ? {rem, quot} : mul_res;

    // High product words and remainders come from the top
    assign upper = state_i.func inside {MD_MULH, MD_MULHSU, MD_MULHU, MD_REM, MD_REMU};

    assign result_o = upper ? full_res[2*XLEN-1:XLEN] : full_res[XLEN-1:0];

endmodule

// ==== hw/muldiv_pkg.sv ====
// Multiply/divide package: widths, function encoding, request, prepared-operand and state structs
package muldiv_pkg;

    // Operand width of the core
    localparam int unsigned XLEN = 32;

    // Product/remainder register holds 2*XLEN plus one guard bit
    localparam int unsigned PROD_W = 2 * XLEN + 1;

    // Step counter width and its "no operation" value
    localparam int unsigned CNT_W = 6;
    localparam logic [CNT_W-1:0] CNT_IDLE = '1;

    // M-extension functions in funct3 order
    // Bit 2 marks a division, bits 2 and 1 together mark a remainder
    typedef enum logic [2:0] {
        MD_MUL    = 3'b000,
        MD_MULH   = 3'b001,
        MD_MULHSU = 3'b010,
        MD_MULHU  = 3'b011,
        MD_DIV    = 3'b100,
        MD_DIVU   = 3'b101,
        MD_REM    = 3'b110,
        MD_REMU   = 3'b111
    } md_func_e;

    // Request from the issue side
    typedef struct packed {
        md_func_e          func;
        // Multiplicand or dividend
        logic [XLEN-1:0]   op_a;
        // Multiplier or divisor
        logic [XLEN-1:0]   op_b;
    } md_req_t;

    // Prepared operands handed to the engine
    typedef struct packed {
        md_func_e          func;
        // Positive multiplicand or dividend
        logic [XLEN-1:0]   mag_a;
        // Positive multiplier, or negative divisor
        logic [XLEN-1:0]   op_b;
        // Result needs its sign flipped at the end
        logic              negate;
        // Result known without iterating
        logic              direct;
        logic [PROD_W-1:0] direct_val;
    } md_prep_t;

    // Engine state seen by the result stage
    typedef struct packed {
        // Product, or remainder above quotient
        logic [PROD_W-1:0] prod;
        md_func_e          func;
        logic              negate;
    } md_state_t;

endpackage

// ==== hw/muldiv_unit.sv ====
// Multiply/divide unit top: operand preparation, iterative engine, result selection
`timescale 1ns/1ps

module muldiv_unit
    import muldiv_pkg::*;
#(
    // 0 radix-4 with early exit, 1 single wide multiply
    parameter int unsigned FAST_MUL = 0
) (
    input  logic            s_clk_i,
    input  logic            arst_n_i,
    // Issue handshake
    input  logic            compute_i,
    input  md_req_t         req_i,
    // Pipeline control from the next stage
    input  logic            stall_i,
    input  logic            flush_i,
    // Result handshake
    output logic            finished_o,
    output logic [XLEN-1:0] result_o
);

    md_prep_t  prep;
    md_state_t state;

    // Decode and sign handling of the incoming request
    md_operand_prep u_prep (
        .req_i  (req_i),
        .prep_o (prep)
    );

    // Sequential product/remainder computation
    md_iter_engine #(
        .FAST_MUL (FAST_MUL)
    ) u_engine (
        .s_clk_i    (s_clk_i),
        .arst_n_i   (arst_n_i),
        .compute_i  (compute_i),
        .stall_i    (stall_i),
        .flush_i    (flush_i),
        .prep_i     (prep),
        .state_o    (state),
        .finished_o (finished_o)
    );

    // Final sign and word select
    md_result_sel u_sel (
        .state_i  (state),
        .result_o (result_o)
    );

endmodule

// ==== list.f ====
+incdir+tests
hw/muldiv_pkg.sv
hw/md_operand_prep.sv
hw/md_iter_engine.sv
hw/md_result_sel.sv
hw/muldiv_unit.sv
tests/tb_muldiv_unit.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the multiply/divide unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module tb_muldiv_unit -o sim_muldiv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_muldiv 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
fi

if echo "$output" | grep -q "^TEST RESULT: PASS$"; then
    exit 0
fi
exit 1

// ==== tests/md_ref_model.svh ====
// Reference model of the RV32 M extension: results and direct-case rules
`ifndef MD_REF_MODEL_SVH
`define MD_REF_MODEL_SVH

// Signed -2^31 / -1 does not fit in 32 bits
function automatic logic ref_is_overflow(input md_func_e func, input logic [31:0] a,
                                         input logic [31:0] b);
    return (func == MD_DIV || func == MD_REM) && a == 32'h8000_0000 && b == 32'hffff_ffff;
endfunction

// Result known without iterating: zero operand, division by zero, overflow
function automatic logic ref_is_direct(input md_func_e func, input logic [31:0] a,
                                       input logic [31:0] b);
    return a == 32'h0 || b == 32'h0 || ref_is_overflow(func, a, b);
endfunction

// Architectural result of one M-extension instruction
function automatic logic [31:0] ref_result(input md_func_e func, input logic [31:0] a,
                                           input logic [31:0] b);
    logic [63:0]        wide_a;
    logic [63:0]        wide_b;
    logic [63:0]        prod;
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    sa = a;
    sb = b;
    // Sign extension picks signed or unsigned operands
    // Low 64 bits of the 64x64 product are exact either way
    wide_a = (func == MD_MULHU) ? {32'h0, a} : {{32{a[31]}}, a};
    wide_b = (func == MD_MUL || func == MD_MULH) ? {{32{b[31]}}, b} : {32'h0, b};
    prod = wide_a * wide_b;
    case (func)
        MD_MUL: return prod[31:0];
        MD_MULH, MD_MULHSU, MD_MULHU: return prod[63:32];
        MD_DIV: begin
            // Division by zero gives all ones
            if (b == 32'h0) return 32'hffff_ffff;
            else if (ref_is_overflow(func, a, b)) return a;
            else return sa / sb;
        end
        MD_DIVU: begin
            if (b == 32'h0) return 32'hffff_ffff;
            else return a / b;
        end
        MD_REM: begin
            // Remainder takes the dividend sign, truncating division
            if (b == 32'h0) return a;
            else if (ref_is_overflow(func, a, b)) return 32'h0;
            else return sa % sb;
        end
        default: begin
            if (b == 32'h0) return a;
            else return a % b;
        end
    endcase
endfunction

`endif

// ==== tests/tb_muldiv_unit.sv ====
// Testbench for the multiply/divide unit: clock, reset, stimulus, assertions, timeout
`timescale 1ns/1ps

module tb_muldiv_unit
    import muldiv_pkg::*;
();

    `include "md_ref_model.svh"

    localparam int FAST_MUL   = 0;
    localparam int CLK_PERIOD = 100;
    localparam int NUM_RAND   = 100;
    // Acceptance to finished_o
    localparam int DIV_LAT    = XLEN + 2;
    localparam int MUL_MAX    = (FAST_MUL != 0) ? 2 : XLEN / 2 + 1;
    // Random mixes of both kinds plus issue/drain cycles, then corner tests
    localparam int TIMEOUT_CYCLES = NUM_RAND * 4 * (DIV_LAT + 3) +
                                    NUM_RAND * 4 * (MUL_MAX + 3) + 4000;

    logic            s_clk;
    logic            arst_n;
    logic            compute;
    logic            stall;
    logic            flush;
    md_req_t         req;
    logic            finished;
    logic [XLEN-1:0] result;

    // Expectation for the operation in flight
    logic [XLEN-1:0] exp_val;
    int              lat_min;
    int              lat_max;
    string           test_name;
    // Outstanding op, first finished seen, cycles since acceptance
    logic            out_q;
    logic            seen_q;
    int              lat_q;
    int              cycle_cnt = 0;
    int              seed;

    muldiv_unit #(
        .FAST_MUL (FAST_MUL)
    ) dut0 (
        .s_clk_i    (s_clk),
        .arst_n_i   (arst_n),
        .compute_i  (compute),
        .req_i      (req),
        .stall_i    (stall),
        .flush_i    (flush),
        .finished_o (finished),
        .result_o   (result)
    );

    initial begin
        s_clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) s_clk = ~s_clk;
        end
    end

    // Tracks the handshake as the issuer sees it
    always @(posedge s_clk or negedge arst_n) begin
        if (!arst_n) begin
            out_q  <= 1'b0;
            seen_q <= 1'b0;
            lat_q  <= 0;
        end else if (flush) begin
            out_q  <= 1'b0;
            seen_q <= 1'b0;
        end else if (compute && !out_q) begin
            out_q  <= 1'b1;
            seen_q <= 1'b0;
            lat_q  <= 1;
        end else if (out_q) begin
            lat_q <= lat_q + 1;
            if (finished) begin
                seen_q <= 1'b1;
                // Stall keeps the result, otherwise the unit goes idle
                if (!stall) begin
                    out_q <= 1'b0;
                end
            end
        end
    end

    always @(posedge s_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles in %s, finished_o never arrived",
                     cycle_cnt, test_name);
            $display("TEST RESULT: FAIL");
            $fatal(1, "run aborted");
        end
    end

    task automatic report_mismatch(input string what, input logic [XLEN-1:0] exp,
                                   input logic [XLEN-1:0] act);
        $display("[FAIL] %s: expected 0x%08h, actual 0x%08h", what, exp, act);
        $display("TEST RESULT: FAIL");
        $fatal(1, "check failed");
    endtask

    task automatic report_latency(input string what, input int lo, input int hi, input int act);
        $display("[FAIL] %s latency: expected %0d..%0d cycles, actual %0d", what, lo, hi, act);
        $display("TEST RESULT: FAIL");
        $fatal(1, "check failed");
    endtask

    // Nothing outstanding, finished_o stays low
    idle_quiet: assert property (@(posedge s_clk) disable iff (!arst_n)
        !out_q |-> !finished)
        else report_mismatch({test_name, " finished_o"}, 32'd0, 32'd1);

    result_match: assert property (@(posedge s_clk) disable iff (!arst_n)
        out_q && finished |-> result == exp_val)
        else report_mismatch(test_name, $sampled(exp_val), $sampled(result));

    // Stalled result must still be offered
    held_finish: assert property (@(posedge s_clk) disable iff (!arst_n)
        out_q && seen_q |-> finished)
        else report_mismatch({test_name, " held finished_o"}, 32'd1, 32'd0);

    latency_window: assert property (@(posedge s_clk) disable iff (!arst_n)
        out_q && finished && !seen_q |-> lat_q >= lat_min && lat_q <= lat_max)
        else report_latency(test_name, lat_min, lat_max, $sampled(lat_q));

    // One request, optionally stalled for hold cycles at finish
    task automatic run_op(input string label, input md_func_e func, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b, input int hold);
        int k;
        test_name = $sformatf("%s %s", label, func.name());
        req.func  = func;
        req.op_a  = a;
        req.op_b  = b;
        exp_val   = ref_result(func, a, b);
        if (ref_is_direct(func, a, b)) begin
            lat_min = 1;
            lat_max = 1;
        end else if (func[2]) begin
            lat_min = DIV_LAT;
            lat_max = DIV_LAT;
        end else begin
            lat_min = 2;
            lat_max = MUL_MAX;
        end
        compute = 1'b1;
        stall   = hold > 0;
        @(negedge s_clk);
        compute = 1'b0;
        // Operands are latched, scramble them
        req.op_a = $random(seed);
        req.op_b = $random(seed);
        while (!finished) begin
            @(negedge s_clk);
        end
        for (k = 0; k < hold; k++) begin
            @(negedge s_clk);
        end
        stall = 1'b0;
        @(negedge s_clk);
    endtask

    function automatic logic [XLEN-1:0] corner_value(input int idx);
        case (idx)
            0: return '0;
            1: return XLEN'(1);
            2: return {1'b1, {(XLEN-1){1'b0}}};
            default: return '1;
        endcase
    endfunction

    task automatic check_products();
        int              i;
        int              j;
        int              k;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        for (i = 0; i < NUM_RAND; i++) begin
            a = $random(seed);
            b = $random(seed);
            for (k = 0; k < 4; k++) begin
                run_op("mul rand", md_func_e'(k[2:0]), a, b, 0);
            end
        end
        // Zero, one and the extremes against each other
        for (i = 0; i < 4; i++) begin
            for (j = 0; j < 4; j++) begin
                for (k = 0; k < 4; k++) begin
                    run_op("mul corner", md_func_e'(k[2:0]), corner_value(i),
                           corner_value(j), 0);
                end
            end
        end
    endtask

    task automatic check_quotients();
        int              i;
        int              k;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        for (i = 0; i < NUM_RAND; i++) begin
            a = $random(seed);
            b = $random(seed);
            // Smaller divisors for wide quotients, sign kept
            if (i % 2 == 1) begin
                b = $signed(b) >>> (i % 29);
            end
            for (k = 4; k < 8; k++) begin
                run_op("div rand", md_func_e'(k[2:0]), a, b, 0);
            end
        end
    endtask

    task automatic check_corners();
        int k;
        for (k = 4; k < 8; k++) begin
            run_op("div by zero", md_func_e'(k[2:0]), $random(seed), '0, 0);
            run_op("min by zero", md_func_e'(k[2:0]), corner_value(2), '0, 0);
            run_op("min by minus one", md_func_e'(k[2:0]), corner_value(2), '1, 0);
        end
        for (k = 0; k < 8; k++) begin
            run_op("zero first operand", md_func_e'(k[2:0]), '0, $random(seed), 0);
        end
    endtask

    // Division aborted part way, then a clean request
    task automatic check_flush();
        int k;
        test_name = "flush DIV";
        req.func  = MD_DIV;
        req.op_a  = $random(seed);
        req.op_b  = $random(seed);
        compute   = 1'b1;
        @(negedge s_clk);
        compute = 1'b0;
        for (k = 0; k < 10; k++) begin
            @(negedge s_clk);
        end
        flush = 1'b1;
        @(negedge s_clk);
        flush = 1'b0;
        for (k = 0; k < DIV_LAT + 4; k++) begin
            @(negedge s_clk);
        end
        run_op("after flush", MD_REM, $random(seed), 32'd7, 0);
    endtask

    initial begin
        seed      = 24569;
        arst_n    = 1'b0;
        compute   = 1'b0;
        stall     = 1'b0;
        flush     = 1'b0;
        req       = '0;
        exp_val   = '0;
        lat_min   = 0;
        lat_max   = 0;
        test_name = "reset";
        repeat (2) @(negedge s_clk);
        arst_n    = 1'b1;
        // Quiet period with compute_i low
        test_name = "idle";
        repeat (5) @(negedge s_clk);
        check_products();
        check_quotients();
        check_corners();
        run_op("stall", MD_DIV, $random(seed), $random(seed), 5);
        run_op("stall", MD_MULH, $random(seed), $random(seed), 3);
        run_op("stall", MD_DIVU, $random(seed), '0, 4);
        check_flush();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
